// ==== rtl/la32_macros.svh ====
`ifndef LA32_MACROS_SVH
`define LA32_MACROS_SVH

// first fetch address after reset
`define LA32_RESET_PC 32'h1c00_0000

`define LA32_NREGS 32

`define LA32_XLEN 32

`endif

// ==== rtl/la32_pkg.sv ====
`include "la32_macros.svh"

package la32_pkg;

    typedef enum logic [2:0] {
        ST_IF  = 3'd0,
        ST_ID  = 3'd1,
        ST_EXE = 3'd2,
        ST_MEM = 3'd3,
        ST_WB  = 3'd4
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   use_rd_as_src2;    // st.w, beq and bne read rd as the second source
        br_kind_t               br_kind;
        logic                   is_load;
        logic                   is_store;
        logic                   reg_write;
        logic [4:0]             rj;
        logic [4:0]             rk;
        logic [4:0]             dest;
        logic [`LA32_XLEN-1:0]  imm;
        logic [`LA32_XLEN-1:0]  br_offs;
    } decode_t;

endpackage

// ==== rtl/regfile.sv ====
`include "la32_macros.svh"

interface regfile_if;
    logic [$clog2(`LA32_NREGS)-1:0] raddr1;
    logic [$clog2(`LA32_NREGS)-1:0] raddr2;
    logic [`LA32_XLEN-1:0]          rdata1;
    logic [`LA32_XLEN-1:0]          rdata2;
    logic                           we;
    logic [$clog2(`LA32_NREGS)-1:0] waddr;
    logic [`LA32_XLEN-1:0]          wdata;

    modport user (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport storage (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

module regfile (
    input logic        clk,
    regfile_if.storage rf
);

    logic [`LA32_XLEN-1:0] regs [`LA32_NREGS];

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != '0) begin    // r0 is never stored
            regs[rf.waddr] <= rf.wdata;
        end
    end

    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

// ==== rtl/fetch_unit.sv ====
`include "la32_macros.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_inst,
    input  logic                  update_pc,
    input  logic                  redirect,
    input  logic [`LA32_XLEN-1:0] redirect_target,
    input  logic [`LA32_XLEN-1:0] inst_sram_rdata,
    output logic [`LA32_XLEN-1:0] inst_sram_addr,
    output logic [`LA32_XLEN-1:0] pc,
    output logic [`LA32_XLEN-1:0] inst
);

    logic [`LA32_XLEN-1:0] seq_pc;

    assign seq_pc = pc + `LA32_XLEN'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `LA32_RESET_PC;
        end else if (update_pc) begin
            pc <= redirect ? redirect_target : seq_pc;    // taken branch or fall through
        end
    end

    // instruction register, loaded during IF from the combinational read
    always_ff @(posedge clk) begin
        if (load_inst) begin
            inst <= inst_sram_rdata;
        end
    end

    assign inst_sram_addr = pc;

endmodule

// ==== rtl/inst_decoder.sv ====
`include "la32_macros.svh"

module inst_decoder (
    input  logic [`LA32_XLEN-1:0] inst,
    output la32_pkg::decode_t     dec
);

    logic [5:0]            op_31_26;
    logic [3:0]            op_25_22;
    logic [1:0]            op_21_20;
    logic [4:0]            op_19_15;
    logic [`LA32_XLEN-1:0] imm_si12;
    logic [`LA32_XLEN-1:0] imm_ui5;
    logic [`LA32_XLEN-1:0] imm_si20;
    logic [`LA32_XLEN-1:0] offs_16;
    logic [`LA32_XLEN-1:0] offs_26;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui5  = {27'b0, inst[14:10]};
    assign imm_si20 = {inst[24:5], 12'b0};
    assign offs_16  = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs_26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};    // offs[25:16] sits in inst[9:0]

    always_comb begin
        dec         = '0;
        dec.alu_op  = la32_pkg::ALU_ADD;
        dec.br_kind = la32_pkg::BR_NONE;
        dec.rj      = inst[9:5];
        dec.rk      = inst[14:10];
        dec.dest    = inst[4:0];
        if (op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
            dec.reg_write = 1'b1;
            case (op_19_15)
                5'h00: dec.alu_op = la32_pkg::ALU_ADD;
                5'h02: dec.alu_op = la32_pkg::ALU_SUB;
                5'h04: dec.alu_op = la32_pkg::ALU_SLT;
                5'h05: dec.alu_op = la32_pkg::ALU_SLTU;
                5'h08: dec.alu_op = la32_pkg::ALU_NOR;
                5'h09: dec.alu_op = la32_pkg::ALU_AND;
                5'h0a: dec.alu_op = la32_pkg::ALU_OR;
                5'h0b: dec.alu_op = la32_pkg::ALU_XOR;
                default: dec.reg_write = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
            dec.reg_write   = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = imm_ui5;
            case (op_19_15)
                5'h01: dec.alu_op = la32_pkg::ALU_SLL;
                5'h09: dec.alu_op = la32_pkg::ALU_SRL;
                5'h11: dec.alu_op = la32_pkg::ALU_SRA;
                default: dec.reg_write = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'ha) begin
            dec.reg_write   = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = imm_si12;
        end else if (op_31_26 == 6'h05 && !inst[25]) begin
            dec.reg_write   = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = imm_si20;
            dec.alu_op      = la32_pkg::ALU_LUI;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h2) begin
            dec.reg_write   = 1'b1;
            dec.is_load     = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = imm_si12;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h6) begin
            dec.is_store       = 1'b1;
            dec.use_rd_as_src2 = 1'b1;
            dec.src2_is_imm    = 1'b1;
            dec.imm            = imm_si12;
        end else if (op_31_26 == 6'h13 || op_31_26 == 6'h15) begin
            dec.reg_write   = 1'b1;
            dec.src1_is_pc  = 1'b1;    // link value is pc + 4 through the ALU
            dec.src2_is_imm = 1'b1;
            dec.imm         = `LA32_XLEN'd4;
            if (op_31_26 == 6'h13) begin
                dec.br_kind = la32_pkg::BR_JIRL;
                dec.br_offs = offs_16;
            end else begin
                dec.br_kind = la32_pkg::BR_BL;
                dec.br_offs = offs_26;
                dec.dest    = 5'd1;
            end
        end else if (op_31_26 == 6'h14) begin
            dec.br_kind = la32_pkg::BR_B;
            dec.br_offs = offs_26;
        end else if (op_31_26 == 6'h16 || op_31_26 == 6'h17) begin
            dec.use_rd_as_src2 = 1'b1;
            dec.br_offs        = offs_16;
            dec.br_kind        = (op_31_26 == 6'h16) ? la32_pkg::BR_BEQ : la32_pkg::BR_BNE;
        end
    end

endmodule

// ==== rtl/alu.sv ====
`include "la32_macros.svh"

module alu (
    input  la32_pkg::alu_op_t     alu_op,
    input  logic [`LA32_XLEN-1:0] alu_src1,
    input  logic [`LA32_XLEN-1:0] alu_src2,
    output logic [`LA32_XLEN-1:0] alu_result
);

    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;
    assign shamt       = alu_src2[4:0];    // only the low five bits count for .w shifts

    always_comb begin
        case (alu_op)
            la32_pkg::ALU_ADD:  alu_result = alu_src1 + alu_src2;
            la32_pkg::ALU_SUB:  alu_result = alu_src1 - alu_src2;
            la32_pkg::ALU_SLT:  alu_result = {{(`LA32_XLEN-1){1'b0}}, lt_signed};
            la32_pkg::ALU_SLTU: alu_result = {{(`LA32_XLEN-1){1'b0}}, lt_unsigned};
            la32_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            la32_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            la32_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            la32_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            la32_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            la32_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            la32_pkg::ALU_SRA:  alu_result = $signed(alu_src1) >>> shamt;
            la32_pkg::ALU_LUI:  alu_result = alu_src2;    // immediate already shifted by the decoder
            default:            alu_result = '0;
        endcase
    end

endmodule

// ==== rtl/state_sequencer.sv ====
`include "la32_macros.svh"

module state_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  la32_pkg::decode_t     dec,
    input  logic [`LA32_XLEN-1:0] pc,
    input  logic [`LA32_XLEN-1:0] alu_result,
    input  logic [`LA32_XLEN-1:0] data_sram_rdata,
    output logic                  load_inst,
    output logic                  update_pc,
    output logic                  redirect,
    output logic [`LA32_XLEN-1:0] redirect_target,
    regfile_if.user               rf,
    output la32_pkg::alu_op_t     alu_op,
    output logic [`LA32_XLEN-1:0] alu_src1,
    output logic [`LA32_XLEN-1:0] alu_src2,
    output logic                  data_sram_we,
    output logic [`LA32_XLEN-1:0] data_sram_addr,
    output logic [`LA32_XLEN-1:0] data_sram_wdata,
    output logic [`LA32_XLEN-1:0] debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [`LA32_XLEN-1:0] debug_wb_rf_wdata
);

    la32_pkg::state_t      state;
    la32_pkg::state_t      state_next;
    la32_pkg::decode_t     dec_q;
    logic [`LA32_XLEN-1:0] pc_q;
    logic [`LA32_XLEN-1:0] rj_q;
    logic [`LA32_XLEN-1:0] rkd_q;
    logic [`LA32_XLEN-1:0] alu_q;
    logic [`LA32_XLEN-1:0] load_q;
    logic                  ends_in_id;
    logic                  rj_eq_rd;
    logic                  wb_write;

    // b, beq and bne finish in ID and never reach EXE
    assign ends_in_id = dec.br_kind inside {la32_pkg::BR_B, la32_pkg::BR_BEQ, la32_pkg::BR_BNE};
    assign rj_eq_rd   = rf.rdata1 == rf.rdata2;

    always_comb begin
        case (state)
            la32_pkg::ST_IF:  state_next = la32_pkg::ST_ID;
            la32_pkg::ST_ID:  state_next = ends_in_id ? la32_pkg::ST_IF : la32_pkg::ST_EXE;
            la32_pkg::ST_EXE: begin
                state_next = (dec_q.is_load || dec_q.is_store) ? la32_pkg::ST_MEM : la32_pkg::ST_WB;
            end
            la32_pkg::ST_MEM: state_next = dec_q.is_load ? la32_pkg::ST_WB : la32_pkg::ST_IF;
            default:          state_next = la32_pkg::ST_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= la32_pkg::ST_IF;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == la32_pkg::ST_ID) begin
            dec_q <= dec;
            pc_q  <= pc;
            rj_q  <= rf.rdata1;
            rkd_q <= rf.rdata2;
        end
        if (state == la32_pkg::ST_EXE) begin
            alu_q <= alu_result;
        end
        if (state == la32_pkg::ST_MEM) begin
            load_q <= data_sram_rdata;
        end
    end

    always_comb begin
        update_pc       = 1'b0;
        redirect        = 1'b0;
        redirect_target = pc + dec.br_offs;
        if (state == la32_pkg::ST_ID && ends_in_id) begin
            update_pc = 1'b1;
            redirect  = (dec.br_kind == la32_pkg::BR_B)
                      || (dec.br_kind == la32_pkg::BR_BEQ && rj_eq_rd)
                      || (dec.br_kind == la32_pkg::BR_BNE && !rj_eq_rd);
        end else if (state == la32_pkg::ST_EXE) begin
            update_pc = 1'b1;
            redirect  = dec_q.br_kind inside {la32_pkg::BR_BL, la32_pkg::BR_JIRL};
            redirect_target = (dec_q.br_kind == la32_pkg::BR_JIRL) ? rj_q + dec_q.br_offs
                                                                    : pc_q + dec_q.br_offs;
        end
    end

    assign load_inst = state == la32_pkg::ST_IF;

    assign rf.raddr1 = dec.rj;
    assign rf.raddr2 = dec.use_rd_as_src2 ? dec.dest : dec.rk;

    assign alu_op   = dec_q.alu_op;
    assign alu_src1 = dec_q.src1_is_pc ? pc_q : rj_q;
    assign alu_src2 = dec_q.src2_is_imm ? dec_q.imm : rkd_q;

    assign data_sram_we    = (state == la32_pkg::ST_MEM) && dec_q.is_store;
    assign data_sram_addr  = alu_q;
    assign data_sram_wdata = rkd_q;    // store data comes from rd

    assign wb_write  = (state == la32_pkg::ST_WB) && dec_q.reg_write;
    assign rf.we     = wb_write;
    assign rf.waddr  = dec_q.dest;
    assign rf.wdata  = dec_q.is_load ? load_q : alu_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{wb_write}};
    assign debug_wb_rf_wnum  = dec_q.dest;
    assign debug_wb_rf_wdata = rf.wdata;

endmodule

// ==== rtl/la32_core.sv ====
`include "la32_macros.svh"

module la32_core (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`LA32_XLEN-1:0] inst_sram_addr,
    input  logic [`LA32_XLEN-1:0] inst_sram_rdata,
    output logic                  data_sram_we,
    output logic [`LA32_XLEN-1:0] data_sram_addr,
    output logic [`LA32_XLEN-1:0] data_sram_wdata,
    input  logic [`LA32_XLEN-1:0] data_sram_rdata,
    output logic [`LA32_XLEN-1:0] debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [`LA32_XLEN-1:0] debug_wb_rf_wdata
);

    logic                  load_inst;
    logic                  update_pc;
    logic                  redirect;
    logic [`LA32_XLEN-1:0] redirect_target;
    logic [`LA32_XLEN-1:0] pc;
    logic [`LA32_XLEN-1:0] inst;
    la32_pkg::decode_t     dec;
    la32_pkg::alu_op_t     alu_op;
    logic [`LA32_XLEN-1:0] alu_src1;
    logic [`LA32_XLEN-1:0] alu_src2;
    logic [`LA32_XLEN-1:0] alu_result;

    regfile_if rf_bus ();

    fetch_unit fetch_unit_i (
        .clk             (clk),
        .reset           (reset),
        .load_inst       (load_inst),
        .update_pc       (update_pc),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_addr  (inst_sram_addr),
        .pc              (pc),
        .inst            (inst)
    );

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    state_sequencer state_sequencer_i (
        .clk               (clk),
        .reset             (reset),
        .dec               (dec),
        .pc                (pc),
        .alu_result        (alu_result),
        .data_sram_rdata   (data_sram_rdata),
        .load_inst         (load_inst),
        .update_pc         (update_pc),
        .redirect          (redirect),
        .redirect_target   (redirect_target),
        .rf                (rf_bus.user),
        .alu_op            (alu_op),
        .alu_src1          (alu_src1),
        .alu_src2          (alu_src2),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile regfile_i (
        .clk (clk),
        .rf  (rf_bus.storage)
    );

    alu alu_i (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

endmodule

// ==== bench/la32_core_properties.sv ====
module la32_core_properties (
    input logic             clk,
    input logic             reset,
    input la32_pkg::state_t state,
    input logic             data_sram_we,
    input logic [3:0]       debug_wb_rf_we
);

    int failures = 0;    // number of failed assertions so far

    if_to_id: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::ST_IF |=> state == la32_pkg::ST_ID)
        else begin
            $error("IF was not followed by ID");
            failures++;
        end

    id_step: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::ST_ID |=> state inside {la32_pkg::ST_IF, la32_pkg::ST_EXE})
        else begin
            $error("illegal state after ID");
            failures++;
        end

    exe_step: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::ST_EXE |=> state inside {la32_pkg::ST_MEM, la32_pkg::ST_WB})
        else begin
            $error("illegal state after EXE");
            failures++;
        end

    mem_step: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::ST_MEM |=> state inside {la32_pkg::ST_WB, la32_pkg::ST_IF})
        else begin
            $error("illegal state after MEM");
            failures++;
        end

    wb_to_if: assert property (@(posedge clk) disable iff (reset)
        state == la32_pkg::ST_WB |=> state == la32_pkg::ST_IF)
        else begin
            $error("WB was not followed by IF");
            failures++;
        end

    // stores only happen in MEM
    we_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == la32_pkg::ST_MEM)
        else begin
            $error("data_sram_we high outside MEM");
            failures++;
        end

    trace_we_whole: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we inside {4'h0, 4'hf})
        else begin
            $error("debug_wb_rf_we is neither all zeros nor all ones");
            failures++;
        end

endmodule

bind state_sequencer la32_core_properties properties_i (.*);

// ==== bench/la32_core_tb.sv ====
`include "la32_macros.svh"

module la32_core_tb;

    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 64;
    localparam logic [9:0] ADDI_W = 10'h00a;
    localparam logic [9:0] LD_W   = 10'h0a2;
    localparam logic [9:0] ST_W   = 10'h0a6;
    localparam logic [5:0] JIRL   = 6'h13;
    localparam logic [5:0] B      = 6'h14;
    localparam logic [5:0] BL     = 6'h15;
    localparam logic [5:0] BEQ    = 6'h16;
    localparam logic [5:0] BNE    = 6'h17;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } wb_t;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] m_dmem [DMEM_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] halt_pc;
    wb_t         exp_q [$];
    integer      seed;
    int          prog_len = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    la32_core la32_core_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] rrr_inst(input logic [4:0] op, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [4:0] rk);
        return {12'h001, op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] shift_inst(input logic [4:0] op, input logic [4:0] rd,
                                               input logic [4:0] rj, input logic [4:0] ui5);
        return {12'h004, op, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_inst(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_inst(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    function automatic logic [31:0] br16_inst(input logic [5:0] op, input logic [4:0] rj,
                                              input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br26_inst(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] offs [4];
        logic [4:0]  rrr_ops [8];
        int          k;
        rrr_ops = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
        for (k = 4; k < 12; k++) begin
            r = $random(seed);
            emit(lu12i_inst(k[4:0], r[31:12]));
            emit(ri12_inst(ADDI_W, k[4:0], k[4:0], r[11:0]));    // random operands in r4..r11
        end
        for (k = 0; k < 8; k++) begin
            emit(rrr_inst(rrr_ops[k], 5'(12 + k), 5'(4 + k), 5'(11 - k)));
        end
        r = $random(seed);
        emit(shift_inst(5'h01, 5'd21, 5'd4, r[4:0]));
        emit(shift_inst(5'h09, 5'd22, 5'd5, r[9:5]));
        emit(shift_inst(5'h11, 5'd23, 5'd6, r[14:10]));
        emit(ri12_inst(ADDI_W, 5'd24, 5'd0, -12'sd1234));
        emit(shift_inst(5'h11, 5'd25, 5'd24, 5'd3));
        emit(ri12_inst(ADDI_W, 5'd26, 5'd7, -12'sd5));
        emit(lu12i_inst(5'd27, r[31:12]));
        emit(ri12_inst(ADDI_W, 5'd20, 5'd0, 12'h100));    // data base address
        for (k = 0; k < 4; k++) begin
            r = $random(seed);
            offs[k] = {6'b0, r[3:0], 2'b0};
            emit(ri12_inst(ST_W, 5'(4 + k), 5'd20, offs[k]));
        end
        for (k = 0; k < 4; k++) begin
            emit(ri12_inst(LD_W, 5'(12 + k), 5'd20, offs[k]));
        end
        r = $random(seed);
        emit(ri12_inst(LD_W, 5'd16, 5'd20, {5'b0, 1'b1, r[3:0], 2'b0}));    // a word never stored
        emit(br16_inst(BEQ, 5'd4, 5'd4, 16'd2));
        emit(ri12_inst(ADDI_W, 5'd30, 5'd0, 12'd1));
        emit(br16_inst(BEQ, 5'd4, 5'd5, 16'd2));
        emit(ri12_inst(ADDI_W, 5'd30, 5'd0, 12'd2));
        emit(br16_inst(BNE, 5'd4, 5'd5, 16'd2));
        emit(ri12_inst(ADDI_W, 5'd30, 5'd0, 12'd3));
        emit(br16_inst(BNE, 5'd4, 5'd4, 16'd2));
        emit(ri12_inst(ADDI_W, 5'd30, 5'd0, 12'd4));
        emit(br26_inst(B, 26'd2));
        emit(ri12_inst(ADDI_W, 5'd30, 5'd0, 12'd5));
        emit(br26_inst(BL, 26'd3));    // call the subroutine three words ahead
        emit(ri12_inst(ADDI_W, 5'd31, 5'd29, 12'd7));
        emit(br26_inst(B, 26'd3));
        emit(ri12_inst(ADDI_W, 5'd29, 5'd0, -12'sd42));
        emit(br16_inst(JIRL, 5'd1, 5'd0, 16'd0));
        emit(ri12_inst(ADDI_W, 5'd0, 5'd4, 12'd0));
        emit(lu12i_inst(5'd0, 20'h12345));
        emit(rrr_inst(5'h00, 5'd28, 5'd0, 5'd0));    // r0 must still read as zero
        halt_pc = `LA32_RESET_PC + 4 * prog_len;
        emit(br26_inst(B, 26'd0));
    endtask

    // architectural model, one instruction per call
    function automatic logic model_step(output logic [31:0] wpc, output logic [4:0] wnum,
                                        output logic [31:0] wdata);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] ea;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic [31:0] next_pc;
        logic        wr;
        ins     = imem[m_pc[8:2]];
        a       = m_regs[ins[9:5]];
        b       = m_regs[ins[14:10]];
        d       = m_regs[ins[4:0]];
        ea      = a + {{20{ins[21]}}, ins[21:10]};
        offs16  = {{14{ins[25]}}, ins[25:10], 2'b0};
        offs26  = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b0};
        next_pc = m_pc + 32'd4;
        wr      = 1'b1;
        wpc     = m_pc;
        wnum    = ins[4:0];
        wdata   = '0;
        casez (ins[31:15])
            17'h00020: wdata = a + b;
            17'h00022: wdata = a - b;
            17'h00024: wdata = {31'b0, $signed(a) < $signed(b)};
            17'h00025: wdata = {31'b0, a < b};
            17'h00028: wdata = ~(a | b);
            17'h00029: wdata = a & b;
            17'h0002a: wdata = a | b;
            17'h0002b: wdata = a ^ b;
            17'h00081: wdata = a << ins[14:10];
            17'h00089: wdata = a >> ins[14:10];
            17'h00091: wdata = $signed(a) >>> ins[14:10];
            17'b0000001010_???????: wdata = ea;    // addi.w
            17'b0010100010_???????: wdata = m_dmem[ea[7:2]];
            17'b0010100110_???????: begin
                wr = 1'b0;
                m_dmem[ea[7:2]] = d;
            end
            17'b0001010_??????????: wdata = {ins[24:5], 12'b0};
            17'b010011_???????????: begin
                wdata   = m_pc + 32'd4;
                next_pc = a + offs16;
            end
            17'b010100_???????????: begin
                wr      = 1'b0;
                next_pc = m_pc + offs26;
            end
            17'b010101_???????????: begin
                wnum    = 5'd1;
                wdata   = m_pc + 32'd4;
                next_pc = m_pc + offs26;
            end
            17'b010110_???????????: begin
                wr = 1'b0;
                if (a == d) next_pc = m_pc + offs16;
            end
            17'b010111_???????????: begin
                wr = 1'b0;
                if (a != d) next_pc = m_pc + offs16;
            end
            default: wr = 1'b0;
        endcase
        if (wr && wnum != 5'd0) begin
            m_regs[wnum] = wdata;
        end
        m_pc = next_pc;
        return wr;
    endfunction

    // both memories answer 1 time unit after the edge
    always @(posedge clk) begin
        #1;
        inst_sram_rdata = imem[inst_sram_addr[8:2]];
        data_sram_rdata = dmem[data_sram_addr[7:2]];
    end

    always @(posedge clk) begin
        if (data_sram_we === 1'b1) begin
            dmem[data_sram_addr[7:2]] <= data_sram_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: the core did not finish the program in %0d cycles",
                               cycle_limit));
        end
    end

    always @(la32_core_i.state_sequencer_i.properties_i.failures) begin
        if (la32_core_i.state_sequencer_i.properties_i.failures != 0) begin
            fail_run("a concurrent assertion on the state sequencer failed");
        end
    end

    initial begin : compare_trace
        wb_t e;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (debug_wb_rf_we !== 4'h0) begin
                if (exp_q.size() == 0) begin
                    fail_run("the core wrote a register after the last expected write");
                end else begin
                    e = exp_q.pop_front();
                    check_value("debug_wb_rf_we", debug_wb_rf_we, 32'hf);
                    check_value("debug_wb_pc", debug_wb_pc, e.pc);
                    check_value("debug_wb_rf_wnum", debug_wb_rf_wnum, e.num);
                    check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, e.data);
                end
            end
        end
    end

    initial begin : main
        logic [31:0] wpc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        int          i;
        int          steps;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        seed            = 32'hdc6e_0ed7;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'hfc00_0000 | (i << 2);    // unused words decode as no-ops
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]   = 32'hc3a5_0000 ^ (i << 2);
            m_dmem[i] = dmem[i];
        end
        build_program();
        m_pc = `LA32_RESET_PC;
        for (i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        steps = 0;
        while (m_pc != halt_pc && steps < 1000) begin
            if (model_step(wpc, wnum, wdata)) begin
                exp_q.push_back({wpc, wnum, wdata});
            end
            steps++;
        end
        if (m_pc != halt_pc) begin
            fail_run("the reference model never reached the end of the program");
        end
        cycle_limit = prog_len * 5 + 50;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("inst_sram_addr", inst_sram_addr, `LA32_RESET_PC);
        check_value("debug_wb_rf_we", debug_wb_rf_we, 32'h0);
        while (exp_q.size() != 0 || inst_sram_addr !== halt_pc) begin
            @(negedge clk);
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], m_dmem[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== la32_core.f ====
+incdir+rtl
rtl/la32_pkg.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/state_sequencer.sv
rtl/la32_core.sv
bench/la32_core_properties.sv
bench/la32_core_tb.sv

// ==== Bender.yml ====
package:
  name: la32_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/la32_pkg.sv
      - rtl/regfile.sv
      - rtl/fetch_unit.sv
      - rtl/inst_decoder.sv
      - rtl/alu.sv
      - rtl/state_sequencer.sv
      - rtl/la32_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/la32_core_properties.sv
      - bench/la32_core_tb.sv
